// File: include/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define ID_XLEN   32
`define ID_REG_AW 5
`define ID_NREGS  32

// major opcode, inst[31:26]
`define ID_OP6_ALU       6'h00
`define ID_OP6_LU12I     6'h05
`define ID_OP6_PCADDU12I 6'h07
`define ID_OP6_MEM       6'h0a
`define ID_OP6_JIRL      6'h13
`define ID_OP6_B         6'h14
`define ID_OP6_BL        6'h15
`define ID_OP6_BEQ       6'h16
`define ID_OP6_BNE       6'h17
`define ID_OP6_BLT       6'h18
`define ID_OP6_BGE       6'h19
`define ID_OP6_BLTU      6'h1a
`define ID_OP6_BGEU      6'h1b

// inst[25:22]
`define ID_OP4_3R    4'h0
`define ID_OP4_SHIFT 4'h1
`define ID_OP4_LD_W  4'h2
`define ID_OP4_ST_W  4'h6
`define ID_OP4_SLTI  4'h8
`define ID_OP4_SLTUI 4'h9
`define ID_OP4_ADDI  4'ha
`define ID_OP4_ANDI  4'hd
`define ID_OP4_ORI   4'he
`define ID_OP4_XORI  4'hf

// inst[21:15] in the 3R and shift-immediate groups
`define ID_OP7_ADD  7'h20
`define ID_OP7_SUB  7'h22
`define ID_OP7_SLT  7'h24
`define ID_OP7_SLTU 7'h25
`define ID_OP7_NOR  7'h28
`define ID_OP7_AND  7'h29
`define ID_OP7_OR   7'h2a
`define ID_OP7_XOR  7'h2b
`define ID_OP7_SLL  7'h2e
`define ID_OP7_SRL  7'h2f
`define ID_OP7_SRA  7'h30
`define ID_OP7_SLLI 7'h01
`define ID_OP7_SRLI 7'h09
`define ID_OP7_SRAI 7'h11

`endif

// File: logic/id_pkg.sv
`include "id_defs.svh"

package id_pkg;

	typedef logic [11:0] alu_op_t; // one-hot

	localparam int ALU_ADD  = 0;
	localparam int ALU_SUB  = 1;
	localparam int ALU_SLT  = 2;
	localparam int ALU_SLTU = 3;
	localparam int ALU_AND  = 4;
	localparam int ALU_NOR  = 5;
	localparam int ALU_OR   = 6;
	localparam int ALU_XOR  = 7;
	localparam int ALU_SLL  = 8;
	localparam int ALU_SRL  = 9;
	localparam int ALU_SRA  = 10;
	localparam int ALU_LUI  = 11;

	typedef enum logic [3:0] {
		BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ,
		BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} br_kind_t;

	typedef struct packed {
		logic [`ID_XLEN-1:0] pc;
		logic [`ID_XLEN-1:0] inst;
	} fetch_pkt_t;

	typedef struct packed {
		alu_op_t               alu_op;
		logic                  src1_is_pc;
		logic                  src2_is_imm;
		logic                  res_from_mem;
		logic                  gr_we;
		logic                  mem_we;
		logic [`ID_REG_AW-1:0] dest;
		logic [`ID_XLEN-1:0]   imm;
		br_kind_t              br_kind;
		logic [`ID_XLEN-1:0]   br_offs;
		logic                  src2_is_rd; // second read port takes rd
	} id_ctrl_t;

	typedef struct packed {
		logic [`ID_XLEN-1:0]   pc;
		logic [`ID_XLEN-1:0]   rj_value;
		logic [`ID_XLEN-1:0]   rkd_value;
		logic [`ID_XLEN-1:0]   imm;
		alu_op_t               alu_op;
		logic                  src1_is_pc;
		logic                  src2_is_imm;
		logic                  res_from_mem;
		logic                  gr_we;
		logic                  mem_we;
		logic [`ID_REG_AW-1:0] dest;
	} id_exe_pkt_t;

endpackage

// File: logic/operand_if.sv
`timescale 1ns/1ps
`include "id_defs.svh"

interface operand_if;
	logic [`ID_REG_AW-1:0] raddr1;
	logic [`ID_REG_AW-1:0] raddr2;
	logic [`ID_XLEN-1:0]   rj_value;
	logic [`ID_XLEN-1:0]   rkd_value;
	logic                  hazard; // load in EXE feeds a source

	modport decoder (
		output raddr1,
		output raddr2
	);

	modport bypass (
		input  raddr1,
		input  raddr2,
		output rj_value,
		output rkd_value,
		output hazard
	);
endinterface

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module inst_decoder
	import id_pkg::*;
(
	input  logic [`ID_XLEN-1:0] inst,
	output id_ctrl_t            ctrl,
	operand_if.decoder          ops
);
	logic [5:0] op6;
	logic [3:0] op4;
	logic [6:0] op7;
	logic [4:0] rd, rj, rk;
	logic [11:0] i12;
	logic [19:0] i20;
	logic [15:0] i16;
	logic [25:0] i26;
	logic grp_alu, grp_3r, grp_sh;
	logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
	logic inst_sll_w, inst_srl_w, inst_sra_w, inst_slli_w, inst_srli_w, inst_srai_w;
	logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
	logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
	logic inst_b, inst_bl, inst_jirl, inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
	logic need_ui5, need_ui12, need_si20, need_si26, src2_is_4, src2_is_rd;
	alu_op_t alu_op;
	logic [`ID_XLEN-1:0] imm;
	logic [`ID_XLEN-1:0] br_offs;

	assign op6 = inst[31:26];
	assign op4 = inst[25:22];
	assign op7 = inst[21:15];
	assign rd  = inst[4:0];
	assign rj  = inst[9:5];
	assign rk  = inst[14:10];
	assign i12 = inst[21:10];
	assign i20 = inst[24:5];
	assign i16 = inst[25:10];
	assign i26 = {inst[9:0], inst[25:10]}; // offs[25:16] sits in the low bits

	assign grp_alu = op6 == `ID_OP6_ALU;
	assign grp_3r  = grp_alu && op4 == `ID_OP4_3R;
	assign grp_sh  = grp_alu && op4 == `ID_OP4_SHIFT;

	assign inst_add_w  = grp_3r && op7 == `ID_OP7_ADD;
	assign inst_sub_w  = grp_3r && op7 == `ID_OP7_SUB;
	assign inst_slt    = grp_3r && op7 == `ID_OP7_SLT;
	assign inst_sltu   = grp_3r && op7 == `ID_OP7_SLTU;
	assign inst_nor    = grp_3r && op7 == `ID_OP7_NOR;
	assign inst_and    = grp_3r && op7 == `ID_OP7_AND;
	assign inst_or     = grp_3r && op7 == `ID_OP7_OR;
	assign inst_xor    = grp_3r && op7 == `ID_OP7_XOR;
	assign inst_sll_w  = grp_3r && op7 == `ID_OP7_SLL;
	assign inst_srl_w  = grp_3r && op7 == `ID_OP7_SRL;
	assign inst_sra_w  = grp_3r && op7 == `ID_OP7_SRA;
	assign inst_slli_w = grp_sh && op7 == `ID_OP7_SLLI;
	assign inst_srli_w = grp_sh && op7 == `ID_OP7_SRLI;
	assign inst_srai_w = grp_sh && op7 == `ID_OP7_SRAI;

	assign inst_addi_w    = grp_alu && op4 == `ID_OP4_ADDI;
	assign inst_slti      = grp_alu && op4 == `ID_OP4_SLTI;
	assign inst_sltui     = grp_alu && op4 == `ID_OP4_SLTUI;
	assign inst_andi      = grp_alu && op4 == `ID_OP4_ANDI;
	assign inst_ori       = grp_alu && op4 == `ID_OP4_ORI;
	assign inst_xori      = grp_alu && op4 == `ID_OP4_XORI;
	assign inst_lu12i_w   = op6 == `ID_OP6_LU12I && !inst[25];
	assign inst_pcaddu12i = op6 == `ID_OP6_PCADDU12I && !inst[25];
	assign inst_ld_w      = op6 == `ID_OP6_MEM && op4 == `ID_OP4_LD_W;
	assign inst_st_w      = op6 == `ID_OP6_MEM && op4 == `ID_OP4_ST_W;

	assign inst_jirl = op6 == `ID_OP6_JIRL;
	assign inst_b    = op6 == `ID_OP6_B;
	assign inst_bl   = op6 == `ID_OP6_BL;
	assign inst_beq  = op6 == `ID_OP6_BEQ;
	assign inst_bne  = op6 == `ID_OP6_BNE;
	assign inst_blt  = op6 == `ID_OP6_BLT;
	assign inst_bge  = op6 == `ID_OP6_BGE;
	assign inst_bltu = op6 == `ID_OP6_BLTU;
	assign inst_bgeu = op6 == `ID_OP6_BGEU;

	assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w |
		inst_jirl | inst_bl | inst_pcaddu12i; // address and link sums
	assign alu_op[ALU_SUB]  = inst_sub_w;
	assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
	assign alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
	assign alu_op[ALU_AND]  = inst_and | inst_andi;
	assign alu_op[ALU_NOR]  = inst_nor;
	assign alu_op[ALU_OR]   = inst_or | inst_ori;
	assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
	assign alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
	assign alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
	assign alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
	assign alu_op[ALU_LUI]  = inst_lu12i_w;

	assign need_ui5   = inst_slli_w | inst_srli_w | inst_srai_w;
	assign need_ui12  = inst_andi | inst_ori | inst_xori;
	assign need_si20  = inst_lu12i_w | inst_pcaddu12i;
	assign need_si26  = inst_b | inst_bl;
	assign src2_is_4  = inst_jirl | inst_bl; // link value pc + 4
	assign src2_is_rd = inst_st_w | inst_beq | inst_bne | inst_blt | inst_bge |
		inst_bltu | inst_bgeu;

	assign imm = src2_is_4 ? 32'd4 :
		need_si20 ? {i20, 12'b0} :
		need_ui12 ? {20'b0, i12} :
		need_ui5  ? {27'b0, rk} :
		{{20{i12[11]}}, i12};

	assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

	always_comb begin
		ctrl.alu_op       = alu_op;
		ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
		ctrl.src2_is_imm  = need_ui5 | need_ui12 | need_si20 | src2_is_4 | inst_addi_w |
			inst_slti | inst_sltui | inst_ld_w | inst_st_w;
		ctrl.res_from_mem = inst_ld_w;
		ctrl.gr_we        = (|alu_op) & ~inst_st_w; // stores use the adder but write no register
		ctrl.mem_we       = inst_st_w;
		ctrl.dest         = inst_bl ? 5'd1 : rd;
		ctrl.imm          = imm;
		ctrl.br_offs      = br_offs;
		ctrl.src2_is_rd   = src2_is_rd;
		if (inst_b)
			ctrl.br_kind = BR_B;
		else if (inst_bl)
			ctrl.br_kind = BR_BL;
		else if (inst_jirl)
			ctrl.br_kind = BR_JIRL;
		else if (inst_beq)
			ctrl.br_kind = BR_BEQ;
		else if (inst_bne)
			ctrl.br_kind = BR_BNE;
		else if (inst_blt)
			ctrl.br_kind = BR_BLT;
		else if (inst_bge)
			ctrl.br_kind = BR_BGE;
		else if (inst_bltu)
			ctrl.br_kind = BR_BLTU;
		else if (inst_bgeu)
			ctrl.br_kind = BR_BGEU;
		else
			ctrl.br_kind = BR_NONE;
	end

	assign ops.raddr1 = rj;
	assign ops.raddr2 = src2_is_rd ? rd : rk;

	always_comb begin
		a_alu_onehot: assert final ($onehot0(alu_op))
			else $error("alu_op has more than one bit set: %h", alu_op);
	end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module reg_file (
	input  logic                  clk,
	input  logic [`ID_REG_AW-1:0] raddr1,
	input  logic [`ID_REG_AW-1:0] raddr2,
	output logic [`ID_XLEN-1:0]   rdata1,
	output logic [`ID_XLEN-1:0]   rdata2,
	input  logic                  we,
	input  logic [`ID_REG_AW-1:0] waddr,
	input  logic [`ID_XLEN-1:0]   wdata
);
	logic [`ID_XLEN-1:0] regs [`ID_NREGS];

	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin // r0 is never written
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired, the array entry stays unused
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: logic/operand_bypass.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module operand_bypass
	import id_pkg::*;
(
	operand_if.bypass             ops,
	input  logic [`ID_XLEN-1:0]   rdata1,
	input  logic [`ID_XLEN-1:0]   rdata2,
	input  logic                  exe_valid,
	input  logic                  exe_we,
	input  logic [`ID_REG_AW-1:0] exe_dest,
	input  logic [`ID_XLEN-1:0]   exe_result,
	input  logic                  exe_is_load,
	input  logic                  mem_valid,
	input  logic                  mem_we,
	input  logic [`ID_REG_AW-1:0] mem_dest,
	input  logic [`ID_XLEN-1:0]   mem_result,
	input  logic                  wb_we,
	input  logic [`ID_REG_AW-1:0] wb_dest,
	input  logic [`ID_XLEN-1:0]   wb_data
);
	logic [`ID_REG_AW-1:0] addr [2];
	logic [`ID_XLEN-1:0]   rf_val [2];
	logic [`ID_XLEN-1:0]   value [2];
	logic [1:0]            nz;
	logic [1:0]            exe_hit;
	logic [1:0]            mem_hit;
	logic [1:0]            wb_hit;

	assign addr[0]   = ops.raddr1;
	assign addr[1]   = ops.raddr2;
	assign rf_val[0] = rdata1;
	assign rf_val[1] = rdata2;

	for (genvar i = 0; i < 2; i++) begin : g_src
		assign nz[i]      = addr[i] != '0;
		assign exe_hit[i] = nz[i] && exe_valid && exe_we && exe_dest == addr[i];
		assign mem_hit[i] = nz[i] && mem_valid && mem_we && mem_dest == addr[i];
		assign wb_hit[i]  = nz[i] && wb_we && wb_dest == addr[i]; // covers same-cycle rf write

		always_comb begin
			if (!nz[i])
				value[i] = '0;
			else if (exe_hit[i])
				value[i] = exe_result;
			else if (mem_hit[i])
				value[i] = mem_result;
			else if (wb_hit[i])
				value[i] = wb_data;
			else
				value[i] = rf_val[i];
		end
	end

	assign ops.rj_value  = value[0];
	assign ops.rkd_value = value[1];
	assign ops.hazard    = exe_is_load && (|exe_hit); // load data not ready until MEM

	// a load that writes no register would slip past the hazard match
	always_comb begin
		a_load_writes_reg: assert final (!(exe_valid === 1'b1 && exe_is_load === 1'b1 &&
			exe_we !== 1'b1))
			else $error("load in EXE without a register write escapes the hazard check");
	end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module branch_unit
	import id_pkg::*;
(
	input  logic                valid,
	input  br_kind_t            br_kind,
	input  logic [`ID_XLEN-1:0] pc,
	input  logic [`ID_XLEN-1:0] br_offs,
	input  logic [`ID_XLEN-1:0] rj_value,
	input  logic [`ID_XLEN-1:0] rkd_value,
	output logic                taken,
	output logic [`ID_XLEN-1:0] target
);
	logic eq;
	logic lt;
	logic ltu;
	logic cond;

	assign eq  = rj_value == rkd_value;
	assign lt  = $signed(rj_value) < $signed(rkd_value);
	assign ltu = rj_value < rkd_value;

	always_comb begin
		case (br_kind)
			BR_B, BR_BL, BR_JIRL: cond = 1'b1;
			BR_BEQ:  cond = eq;
			BR_BNE:  cond = !eq;
			BR_BLT:  cond = lt;
			BR_BGE:  cond = !lt;
			BR_BLTU: cond = ltu;
			BR_BGEU: cond = !ltu;
			default: cond = 1'b0;
		endcase
	end

	assign taken  = valid && cond; // only a leaving instruction redirects fetch
	assign target = (br_kind == BR_JIRL) ? rj_value + br_offs : pc + br_offs;

endmodule

// File: logic/id_stage.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage
	import id_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  fetch_pkt_t            in_pkt,
	output logic                  out_valid,
	input  logic                  out_ready,
	output id_exe_pkt_t           out_pkt,
	input  logic                  flush,
	input  logic                  exe_valid,
	input  logic                  exe_we,
	input  logic [`ID_REG_AW-1:0] exe_dest,
	input  logic [`ID_XLEN-1:0]   exe_result,
	input  logic                  exe_is_load,
	input  logic                  mem_valid,
	input  logic                  mem_we,
	input  logic [`ID_REG_AW-1:0] mem_dest,
	input  logic [`ID_XLEN-1:0]   mem_result,
	input  logic                  wb_we,
	input  logic [`ID_REG_AW-1:0] wb_dest,
	input  logic [`ID_XLEN-1:0]   wb_data,
	output logic                  br_taken,
	output logic [`ID_XLEN-1:0]   br_target,
	output logic                  br_stall
);
	logic                stage_valid;
	fetch_pkt_t          stage_pkt;
	id_ctrl_t            ctrl;
	logic [`ID_XLEN-1:0] rdata1;
	logic [`ID_XLEN-1:0] rdata2;
	logic                ready_go;

	operand_if ops ();

	assign ready_go  = !ops.hazard;
	assign in_ready  = !stage_valid || (ready_go && out_ready);
	assign out_valid = stage_valid && ready_go;
	assign br_stall  = stage_valid && ops.hazard;

	always_ff @(posedge clk) begin
		if (reset)
			stage_valid <= 1'b0;
		else if (flush)
			stage_valid <= 1'b0;
		else if (in_ready)
			stage_valid <= in_valid && !br_taken; // wrong-path fetch behind a taken branch
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			stage_pkt <= in_pkt;
	end

	inst_decoder u_decoder (.inst(stage_pkt.inst), .ctrl(ctrl), .ops(ops.decoder));

	reg_file u_reg_file (
		.clk   (clk),
		.raddr1(ops.raddr1),
		.raddr2(ops.raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we    (wb_we),
		.waddr (wb_dest),
		.wdata (wb_data)
	);

	operand_bypass u_bypass (
		.ops        (ops.bypass),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.exe_valid  (exe_valid),
		.exe_we     (exe_we),
		.exe_dest   (exe_dest),
		.exe_result (exe_result),
		.exe_is_load(exe_is_load),
		.mem_valid  (mem_valid),
		.mem_we     (mem_we),
		.mem_dest   (mem_dest),
		.mem_result (mem_result),
		.wb_we      (wb_we),
		.wb_dest    (wb_dest),
		.wb_data    (wb_data)
	);

	branch_unit u_branch (
		.valid    (out_valid),
		.br_kind  (ctrl.br_kind),
		.pc       (stage_pkt.pc),
		.br_offs  (ctrl.br_offs),
		.rj_value (ops.rj_value),
		.rkd_value(ops.rkd_value),
		.taken    (br_taken),
		.target   (br_target)
	);

	always_comb begin
		out_pkt.pc           = stage_pkt.pc;
		out_pkt.rj_value     = ops.rj_value;
		out_pkt.rkd_value    = ops.rkd_value;
		out_pkt.imm          = ctrl.imm;
		out_pkt.alu_op       = ctrl.alu_op;
		out_pkt.src1_is_pc   = ctrl.src1_is_pc;
		out_pkt.src2_is_imm  = ctrl.src2_is_imm;
		out_pkt.res_from_mem = ctrl.res_from_mem;
		out_pkt.gr_we        = ctrl.gr_we;
		out_pkt.mem_we       = ctrl.mem_we;
		out_pkt.dest         = ctrl.dest;
	end

	// downstream back-pressure must not disturb the offered instruction
	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready && !flush |=> $stable(out_pkt))
		else $error("out_pkt changed while held by out_ready");

endmodule

// File: verification/id_stage_tb.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage_tb
	import id_pkg::*;
();
	localparam int WAIT_LIMIT = 50;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	fetch_pkt_t            in_pkt;
	logic                  out_valid;
	logic                  out_ready;
	id_exe_pkt_t           out_pkt;
	logic                  flush;
	logic                  exe_valid, exe_we, exe_is_load;
	logic [`ID_REG_AW-1:0] exe_dest;
	logic [`ID_XLEN-1:0]   exe_result;
	logic                  mem_valid, mem_we;
	logic [`ID_REG_AW-1:0] mem_dest;
	logic [`ID_XLEN-1:0]   mem_result;
	logic                  wb_we;
	logic [`ID_REG_AW-1:0] wb_dest;
	logic [`ID_XLEN-1:0]   wb_data;
	logic                  br_taken;
	logic [`ID_XLEN-1:0]   br_target;
	logic                  br_stall;

	logic [31:0] shadow [32]; // reference copy of the register file
	logic [31:0] rng_state;
	logic [31:0] cur_inst;
	logic [31:0] cur_pc;
	id_exe_pkt_t want;
	br_kind_t    want_kind;
	logic [31:0] want_offs;
	logic        want_taken;
	logic [31:0] want_target;
	logic        want_src2_rd;
	logic        imm_care;
	logic        chk, stall_chk, empty_chk;
	logic        leaving;
	logic [4:0]  got_flags, want_flags;
	int          fail_count;

	id_stage dut_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (wb_we && wb_dest != 5'd0)
			shadow[wb_dest] <= wb_data;
	end

	assign leaving    = out_valid && out_ready && chk;
	assign got_flags  = {out_pkt.src1_is_pc, out_pkt.src2_is_imm, out_pkt.res_from_mem,
		out_pkt.gr_we, out_pkt.mem_we};
	assign want_flags = {want.src1_is_pc, want.src2_is_imm, want.res_from_mem,
		want.gr_we, want.mem_we};

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp_val);
		fail_count++;
		$display("MISMATCH %s: got %h expected %h", name, got, exp_val);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		fail_count++;
		$display("ERROR: %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	a_pc: assert property (@(posedge clk) disable iff (reset) leaving |-> out_pkt.pc == want.pc)
		else report_mismatch("pc", $sampled(out_pkt.pc), $sampled(want.pc));
	a_rj: assert property (@(posedge clk) disable iff (reset)
		leaving |-> out_pkt.rj_value == want.rj_value)
		else report_mismatch("rj_value", $sampled(out_pkt.rj_value), $sampled(want.rj_value));
	a_rkd: assert property (@(posedge clk) disable iff (reset)
		leaving |-> out_pkt.rkd_value == want.rkd_value)
		else report_mismatch("rkd_value", $sampled(out_pkt.rkd_value), $sampled(want.rkd_value));
	a_imm: assert property (@(posedge clk) disable iff (reset)
		leaving && imm_care |-> out_pkt.imm == want.imm)
		else report_mismatch("imm", $sampled(out_pkt.imm), $sampled(want.imm));
	a_alu_op: assert property (@(posedge clk) disable iff (reset)
		leaving |-> out_pkt.alu_op == want.alu_op)
		else report_mismatch("alu_op", $sampled(out_pkt.alu_op), $sampled(want.alu_op));
	a_flags: assert property (@(posedge clk) disable iff (reset) leaving |-> got_flags == want_flags)
		else report_mismatch("src1_is_pc,src2_is_imm,res_from_mem,gr_we,mem_we",
			$sampled(got_flags), $sampled(want_flags));
	a_dest: assert property (@(posedge clk) disable iff (reset)
		leaving && want.gr_we |-> out_pkt.dest == want.dest)
		else report_mismatch("dest", $sampled(out_pkt.dest), $sampled(want.dest));
	a_taken: assert property (@(posedge clk) disable iff (reset) leaving |-> br_taken == want_taken)
		else report_mismatch("br_taken", $sampled(br_taken), $sampled(want_taken));
	a_target: assert property (@(posedge clk) disable iff (reset)
		leaving && want_taken |-> br_target == want_target)
		else report_mismatch("br_target", $sampled(br_target), $sampled(want_target));
	a_hold: assert property (@(posedge clk) disable iff (reset) out_valid && !out_ready |-> !in_ready)
		else report_error("in_ready high while the output was held");
	a_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready && !flush |=> $stable(out_pkt))
		else report_error("out_pkt changed while out_ready was low");
	a_stall: assert property (@(posedge clk) disable iff (reset)
		stall_chk |-> br_stall && !out_valid && !in_ready)
		else report_error("load-use hazard did not hold the instruction");
	a_empty: assert property (@(posedge clk) disable iff (reset)
		empty_chk |-> !out_valid && !br_taken && !br_stall)
		else report_error("stage not empty after reset, flush or taken branch");

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [4:0] rnd_reg();
		logic [31:0] r;
		r = rand32();
		return r[4:0];
	endfunction

	// youngest writer first, r0 hardwired
	function automatic logic [31:0] ref_value(input logic [4:0] a);
		if (a == 5'd0)
			return 32'd0;
		if (exe_valid && exe_we && exe_dest == a)
			return exe_result;
		if (mem_valid && mem_we && mem_dest == a)
			return mem_result;
		if (wb_we && wb_dest == a)
			return wb_data;
		return shadow[a];
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
		wb_we = 1'b1;
		wb_dest = addr;
		wb_data = data;
		step();
		wb_we = 1'b0;
	endtask

	task automatic clear_want();
		want = '0;
		imm_care = 1'b1;
		want_src2_rd = 1'b0;
		want_kind = BR_NONE;
		want_offs = '0;
	endtask

	task automatic three_reg(input logic [6:0] op7, input int bit_idx,
		input logic [4:0] rd, rj, rk);
		clear_want();
		cur_inst = {`ID_OP6_ALU, `ID_OP4_3R, op7, rk, rj, rd};
		want.alu_op[bit_idx] = 1'b1;
		want.gr_we = 1'b1;
		want.dest = rd;
		imm_care = 1'b0; // no immediate field here
	endtask

	task automatic shift_by_imm(input logic [6:0] op7, input int bit_idx,
		input logic [4:0] rd, rj, input logic [31:0] r);
		clear_want();
		cur_inst = {`ID_OP6_ALU, `ID_OP4_SHIFT, op7, r[4:0], rj, rd};
		want.alu_op[bit_idx] = 1'b1;
		want.src2_is_imm = 1'b1;
		want.imm = {27'b0, r[4:0]};
		want.gr_we = 1'b1;
		want.dest = rd;
	endtask

	task automatic reg_imm12(input logic [3:0] op4, input int bit_idx, input logic zext,
		input logic [4:0] rd, rj, input logic [31:0] r);
		clear_want();
		cur_inst = {`ID_OP6_ALU, op4, r[11:0], rj, rd};
		want.alu_op[bit_idx] = 1'b1;
		want.src2_is_imm = 1'b1;
		want.imm = zext ? {20'b0, r[11:0]} : {{20{r[11]}}, r[11:0]};
		want.gr_we = 1'b1;
		want.dest = rd;
	endtask

	task automatic upper_imm(input logic is_pc, input logic [4:0] rd, input logic [31:0] r);
		clear_want();
		cur_inst = {is_pc ? `ID_OP6_PCADDU12I : `ID_OP6_LU12I, 1'b0, r[19:0], rd};
		want.alu_op[is_pc ? ALU_ADD : ALU_LUI] = 1'b1;
		want.src1_is_pc = is_pc;
		want.src2_is_imm = 1'b1;
		want.imm = {r[19:0], 12'b0};
		want.gr_we = 1'b1;
		want.dest = rd;
	endtask

	task automatic load_store(input logic store, input logic [4:0] rd, rj,
		input logic [31:0] r);
		clear_want();
		cur_inst = {`ID_OP6_MEM, store ? `ID_OP4_ST_W : `ID_OP4_LD_W, r[11:0], rj, rd};
		want.alu_op[ALU_ADD] = 1'b1; // address sum
		want.src2_is_imm = 1'b1;
		want.imm = {{20{r[11]}}, r[11:0]};
		want.mem_we = store;
		want.res_from_mem = !store;
		want.gr_we = !store;
		want.dest = rd;
		want_src2_rd = store;
	endtask

	task automatic branch_inst(input br_kind_t kind, input logic [4:0] rd, rj,
		input logic [31:0] offs);
		logic [5:0] op6;
		case (kind)
			BR_B:    op6 = `ID_OP6_B;
			BR_BL:   op6 = `ID_OP6_BL;
			BR_JIRL: op6 = `ID_OP6_JIRL;
			BR_BEQ:  op6 = `ID_OP6_BEQ;
			BR_BNE:  op6 = `ID_OP6_BNE;
			BR_BLT:  op6 = `ID_OP6_BLT;
			BR_BGE:  op6 = `ID_OP6_BGE;
			BR_BLTU: op6 = `ID_OP6_BLTU;
			default: op6 = `ID_OP6_BGEU;
		endcase
		clear_want();
		want_kind = kind;
		if (kind == BR_B || kind == BR_BL) begin
			cur_inst = {op6, offs[15:0], offs[25:16]};
			want_offs = {{4{offs[25]}}, offs[25:0], 2'b00};
		end else begin
			cur_inst = {op6, offs[15:0], rj, rd};
			want_offs = {{14{offs[15]}}, offs[15:0], 2'b00};
		end
		if (kind == BR_BL || kind == BR_JIRL) begin // link write of pc + 4
			want.alu_op[ALU_ADD] = 1'b1;
			want.src1_is_pc = 1'b1;
			want.src2_is_imm = 1'b1;
			want.imm = 32'd4;
			want.gr_we = 1'b1;
			want.dest = (kind == BR_BL) ? 5'd1 : rd;
		end else begin
			imm_care = 1'b0;
		end
		want_src2_rd = kind != BR_B && kind != BR_BL && kind != BR_JIRL;
	endtask

	task automatic send_inst();
		int n;
		n = 0;
		cur_pc = cur_pc + 32'd4;
		in_pkt.pc = cur_pc;
		in_pkt.inst = cur_inst;
		in_valid = 1'b1;
		#1;
		while (!in_ready) begin
			n++;
			if (n > WAIT_LIMIT)
				report_error("timed out waiting for in_ready");
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic predict_and_leave();
		logic [4:0]  ra1;
		logic [4:0]  ra2;
		logic [31:0] rj_val;
		logic [31:0] rkd_val;
		int          n;
		ra1 = cur_inst[9:5];
		ra2 = want_src2_rd ? cur_inst[4:0] : cur_inst[14:10];
		rj_val = ref_value(ra1);
		rkd_val = ref_value(ra2);
		want.pc = cur_pc;
		want.rj_value = rj_val;
		want.rkd_value = rkd_val;
		case (want_kind)
			BR_B, BR_BL, BR_JIRL: want_taken = 1'b1;
			BR_BEQ:  want_taken = rj_val == rkd_val;
			BR_BNE:  want_taken = rj_val != rkd_val;
			BR_BLT:  want_taken = $signed(rj_val) < $signed(rkd_val);
			BR_BGE:  want_taken = $signed(rj_val) >= $signed(rkd_val);
			BR_BLTU: want_taken = rj_val < rkd_val;
			BR_BGEU: want_taken = rj_val >= rkd_val;
			default: want_taken = 1'b0;
		endcase
		want_target = ((want_kind == BR_JIRL) ? rj_val : cur_pc) + want_offs;
		chk = 1'b1;
		n = 0;
		#1;
		while (!out_valid) begin
			n++;
			if (n > WAIT_LIMIT)
				report_error("timed out waiting for out_valid");
			@(posedge clk);
			#2;
		end
		@(posedge clk); // the transfer edge, checked by the assertions
		#1;
	endtask

	task automatic run_inst();
		send_inst();
		predict_and_leave();
	endtask

	initial begin
		rng_state = 32'h176d_3a1a;
		fail_count = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pkt = '0;
		out_ready = 1'b1;
		flush = 1'b0;
		{exe_valid, exe_we, exe_is_load, exe_dest, exe_result} = '0;
		{mem_valid, mem_we, mem_dest, mem_result} = '0;
		{wb_we, wb_dest, wb_data} = '0;
		cur_pc = 32'h1c00_0000;
		cur_inst = '0;
		clear_want();
		{want_taken, want_target, chk, stall_chk, empty_chk} = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		empty_chk = 1'b1;
		for (int r = 1; r < 32; r++)
			wb_write(5'(r), rand32());
		wb_write(5'd0, 32'hdead_beef); // must not stick
		empty_chk = 1'b0;

		three_reg(`ID_OP7_ADD, ALU_ADD, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SUB, ALU_SUB, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SLT, ALU_SLT, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SLTU, ALU_SLTU, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_NOR, ALU_NOR, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_AND, ALU_AND, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_OR, ALU_OR, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_XOR, ALU_XOR, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SLL, ALU_SLL, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SRL, ALU_SRL, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		three_reg(`ID_OP7_SRA, ALU_SRA, rnd_reg(), rnd_reg(), rnd_reg());
		run_inst();
		shift_by_imm(`ID_OP7_SLLI, ALU_SLL, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		shift_by_imm(`ID_OP7_SRLI, ALU_SRL, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		shift_by_imm(`ID_OP7_SRAI, ALU_SRA, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_ADDI, ALU_ADD, 1'b0, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_SLTI, ALU_SLT, 1'b0, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_SLTUI, ALU_SLTU, 1'b0, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_ANDI, ALU_AND, 1'b1, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_ORI, ALU_OR, 1'b1, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		reg_imm12(`ID_OP4_XORI, ALU_XOR, 1'b1, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		upper_imm(1'b0, rnd_reg(), rand32());
		run_inst();
		upper_imm(1'b1, rnd_reg(), rand32());
		run_inst();
		load_store(1'b0, rnd_reg(), rnd_reg(), rand32());
		run_inst();
		load_store(1'b1, rnd_reg(), rnd_reg(), rand32());
		run_inst();

		// write then read back, r0 stays zero even with a live wb to it
		wb_write(5'd9, rand32());
		three_reg(`ID_OP7_OR, ALU_OR, 5'd4, 5'd9, 5'd9);
		run_inst();
		{wb_we, wb_dest, wb_data} = {1'b1, 5'd0, 32'h1234_5678};
		three_reg(`ID_OP7_ADD, ALU_ADD, 5'd4, 5'd0, 5'd0);
		run_inst();

		// all three writers aim at r5
		{exe_valid, exe_we, exe_dest, exe_result} = {1'b1, 1'b1, 5'd5, rand32()};
		{mem_valid, mem_we, mem_dest, mem_result} = {1'b1, 1'b1, 5'd5, rand32()};
		{wb_we, wb_dest, wb_data} = {1'b1, 5'd5, rand32()};
		three_reg(`ID_OP7_ADD, ALU_ADD, 5'd2, 5'd5, 5'd5);
		run_inst();
		exe_valid = 1'b0;
		run_inst();
		mem_valid = 1'b0;
		send_inst();
		wb_data = rand32(); // not yet in the register file
		predict_and_leave();
		wb_we = 1'b0;

		// load-use, later resolved through MEM
		{exe_valid, exe_we, exe_is_load, exe_dest, exe_result} = {3'b111, 5'd7, rand32()};
		three_reg(`ID_OP7_ADD, ALU_ADD, 5'd3, 5'd7, 5'd8);
		send_inst();
		stall_chk = 1'b1;
		repeat (3) step();
		stall_chk = 1'b0;
		{exe_valid, exe_is_load} = 2'b00;
		{mem_valid, mem_we, mem_dest, mem_result} = {1'b1, 1'b1, 5'd7, rand32()};
		predict_and_leave();
		mem_valid = 1'b0;

		wb_write(5'd20, 32'h8000_0000);
		wb_write(5'd21, 32'h0000_0001);
		wb_write(5'd22, 32'h0000_0001);
		for (int k = BR_BEQ; k <= BR_BGEU; k++) begin
			branch_inst(br_kind_t'(k), 5'd21, 5'd22, rand32()); // equal operands
			run_inst();
			branch_inst(br_kind_t'(k), 5'd21, 5'd20, rand32()); // signed and unsigned disagree
			run_inst();
			branch_inst(br_kind_t'(k), 5'd20, 5'd21, rand32());
			run_inst();
		end
		branch_inst(BR_B, 5'd0, 5'd0, rand32());
		run_inst();
		branch_inst(BR_BL, 5'd0, 5'd0, rand32());
		run_inst();
		branch_inst(BR_JIRL, rnd_reg(), rnd_reg(), rand32());
		run_inst();

		// wrong-path instruction arrives as a taken b leaves
		branch_inst(BR_B, 5'd0, 5'd0, rand32());
		send_inst();
		in_pkt.pc = cur_pc + 32'd4;
		in_pkt.inst = {`ID_OP6_ALU, `ID_OP4_3R, `ID_OP7_ADD, 5'd1, 5'd2, 5'd3};
		in_valid = 1'b1;
		predict_and_leave();
		in_valid = 1'b0;
		empty_chk = 1'b1;
		repeat (2) step();
		empty_chk = 1'b0;

		// back-pressure with a younger instruction waiting upstream, then flush
		out_ready = 1'b0;
		three_reg(`ID_OP7_XOR, ALU_XOR, rnd_reg(), rnd_reg(), rnd_reg());
		send_inst();
		in_pkt.pc = cur_pc + 32'd4;
		in_pkt.inst = {`ID_OP6_ALU, `ID_OP4_3R, `ID_OP7_AND, 5'd6, 5'd5, 5'd4};
		in_valid = 1'b1;
		repeat (4) step();
		in_valid = 1'b0;
		flush = 1'b1;
		step();
		flush = 1'b0;
		empty_chk = 1'b1;
		repeat (2) step();
		empty_chk = 1'b0;
		out_ready = 1'b1;
		run_inst();

		step();
		if (fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
logic/id_pkg.sv
logic/operand_if.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
verification/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - logic/id_pkg.sv
      - logic/operand_if.sv
      - logic/inst_decoder.sv
      - logic/reg_file.sv
      - logic/operand_bypass.sv
      - logic/branch_unit.sv
      - logic/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/id_stage_tb.sv
